// File: dv/zx_memory_props.sv
// Handshake and clock enable properties bound into zx_memory_top; failures are also counted in fail_count
`timescale 1ns/1ns

module zx_memory_props (
	input logic               clk_sys,
	input logic               reset,
	input logic               cpu_req_i,
	input logic               cpu_ack_i,
	input logic               ld_req_i,
	input logic               ld_ack_i,
	input logic               ram_ready_i,
	input logic               ce_cpu_i,
	input zx_mem_pkg::turbo_t turbo_i,
	input logic               cpu_mreq_n_i,
	input logic               cpu_rd_n_i,
	input logic               dl_active_i
);

	int fail_count = 0;

	// ======================================================================
	// Toggle handshake
	// ======================================================================
	cpu_ack_follows_req: assert property (@(posedge clk_sys) disable iff (reset)
		(cpu_ack_i != $past(cpu_ack_i)) |-> ($past(cpu_req_i) != $past(cpu_ack_i)))
		else begin
			$error("CPU ack toggled with no request pending");
			fail_count++;
		end

	ld_ack_follows_req: assert property (@(posedge clk_sys) disable iff (reset)
		(ld_ack_i != $past(ld_ack_i)) |-> ($past(ld_req_i) != $past(ld_ack_i)))
		else begin
			$error("Loader ack toggled with no request pending");
			fail_count++;
		end

	// New request only once the previous one is done
	cpu_req_after_done: assert property (@(posedge clk_sys) disable iff (reset)
		(cpu_req_i != $past(cpu_req_i)) |-> ($past(cpu_req_i) == $past(cpu_ack_i)))
		else begin
			$error("CPU request toggled before completion");
			fail_count++;
		end

	// Ready drops with a new read strobe, and the request is out one cycle later
	ready_low_on_read: assert property (@(posedge clk_sys) disable iff (reset)
		($rose(!cpu_mreq_n_i && !cpu_rd_n_i) && !dl_active_i)
			|-> !ram_ready_i ##1 (!ram_ready_i && (cpu_req_i != cpu_ack_i)))
		else begin
			$error("ram_ready high while a CPU read is starting or pending");
			fail_count++;
		end

	// ======================================================================
	// CPU clock enable
	// ======================================================================
	no_ce_when_busy: assert property (@(posedge clk_sys) disable iff (reset)
		!ram_ready_i |-> !ce_cpu_i)
		else begin
			$error("ce_cpu pulse while memory busy");
			fail_count++;
		end

	ce_stall_on_turbo: assert property (@(posedge clk_sys) disable iff (reset)
		(turbo_i != $past(turbo_i)) |-> !ce_cpu_i ##1 !ce_cpu_i ##1 !ce_cpu_i ##1 !ce_cpu_i)
		else begin
			$error("ce_cpu pulse within 4 cycles of a turbo change");
			fail_count++;
		end

endmodule

// File: dv/zx_memory_tb.sv
// Testbench for zx_memory_top; the full 32K ROM download dominates the run time
`timescale 1ns/1ns

module zx_memory_tb;

	localparam int CLK_PERIOD  = 4;
	localparam int ROM_BYTES   = 32768;
	localparam int N_READS     = 24;
	localparam int N_OFFS      = 4;
	localparam int N_OVL       = 32;
	localparam int N_GAPS      = 4;
	localparam int READY_LIMIT = 32;
	// One transfer is a strobe, bus cycle or ce pulse, none longer than 40 cycles
	localparam int N_TRANSFERS = ROM_BYTES + 4 * N_READS + 36 * N_OFFS + 4 * N_OVL
		+ 5 * (N_GAPS + 2) + 200;
	localparam int WATCHDOG_CYCLES = N_TRANSFERS * 40;

	logic                  clk_sys;
	logic                  reset;
	zx_mem_pkg::cpu_addr_t cpu_addr;
	zx_mem_pkg::byte_t     cpu_dout;
	logic                  cpu_mreq_n;
	logic                  cpu_iorq_n;
	logic                  cpu_rd_n;
	logic                  cpu_wr_n;
	logic                  cpu_m1_n;
	logic                  mode_48k;
	zx_mem_pkg::turbo_t    turbo;
	logic                  dl_active;
	logic                  dl_wr;
	zx_mem_pkg::byte_t     dl_index;
	logic [17:0]           dl_addr;
	zx_mem_pkg::byte_t     dl_data;
	zx_mem_pkg::byte_t     cpu_din;
	logic                  ram_ready;
	logic                  ce_cpu;
	zx_mem_pkg::byte_t     page_reg;

	logic [15:0]       lfsr_q;
	zx_mem_pkg::byte_t ref_mem [int];  // Expected memory, keyed by physical address
	zx_mem_pkg::byte_t ref_page;
	logic [13:0]       offs [N_OFFS];
	logic [13:0]       ld_offs [N_OVL];
	logic [13:0]       cpu_offs [N_OVL];
	int                i;
	int                k;

	zx_memory_top #(.PHYS_ADDR_W(18), .CE_DIV_W(5)) u_zx_memory_top (
		.clk_sys, .reset,
		.cpu_addr_i (cpu_addr), .cpu_dout_i (cpu_dout), .cpu_mreq_n_i (cpu_mreq_n),
		.cpu_iorq_n_i (cpu_iorq_n), .cpu_rd_n_i (cpu_rd_n), .cpu_wr_n_i (cpu_wr_n),
		.cpu_m1_n_i (cpu_m1_n), .mode_48k_i (mode_48k), .turbo_i (turbo),
		.dl_active_i (dl_active), .dl_wr_i (dl_wr), .dl_index_i (dl_index),
		.dl_addr_i (dl_addr), .dl_data_i (dl_data),
		.cpu_din_o (cpu_din), .ram_ready_o (ram_ready), .ce_cpu_o (ce_cpu),
		.page_reg_o (page_reg)
	);

	bind zx_memory_top zx_memory_props u_zx_memory_props (
		.clk_sys (clk_sys), .reset (reset), .cpu_req_i (cpu_req), .cpu_ack_i (cpu_ack),
		.ld_req_i (ld_req), .ld_ack_i (ld_ack), .ram_ready_i (ram_ready_o),
		.ce_cpu_i (ce_cpu_o), .turbo_i (turbo_i), .cpu_mreq_n_i (cpu_mreq_n_i),
		.cpu_rd_n_i (cpu_rd_n_i), .dl_active_i (dl_active_i)
	);

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Watchdog expired after %0d cycles without finishing", WATCHDOG_CYCLES);
		$display("Test failed");
		$fatal(1, "Watchdog timeout");
	end

	always @(u_zx_memory_top.u_zx_memory_props.fail_count) begin
		if (u_zx_memory_top.u_zx_memory_props.fail_count != 0) begin
			$display("A bound property failed at %0t", $time);
			$display("Test failed");
			$fatal(1, "Property failure");
		end
	end

	// ======================================================================
	// Helpers
	// ======================================================================
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		logic        fb;
		int          j;
		r = '0;
		for (j = 0; j < n; j++) begin
			fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];  // x^16+x^14+x^13+x^11+1
			lfsr_q = {lfsr_q[14:0], fb};
			r      = {r[30:0], fb};
		end
		return r;
	endfunction

	// Z80 address to physical address under the 128K paging rules
	function automatic int map_addr(input logic [15:0] a);
		int bank;
		if (a[15:14] == 2'b00)
			return int'(zx_mem_pkg::ROM_BASE) + ((mode_48k || ref_page[4]) ? 16384 : 0) + a[13:0];
		case (a[15:14])
			2'b01:   bank = 5;
			2'b10:   bank = 2;
			default: bank = mode_48k ? 0 : int'(ref_page[2:0]);
		endcase
		return int'(zx_mem_pkg::RAM_BASE) + bank * 16384 + a[13:0];
	endfunction

	task automatic step();
		@(posedge clk_sys);
		#1;
	endtask

	task automatic expect_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp) else begin
			$display("Mismatch at %0t: %s is %0h, expected %0h", $time, name, got, exp);
			$display("Test failed");
			$fatal(1, "Value check failed");
		end
	endtask

	task automatic apply_reset();
		reset = 1'b1;
		repeat (3) step();
		reset    = 1'b0;
		ref_page = '0;
	endtask

	task automatic wait_ready();
		int n;
		n = 0;
		@(negedge clk_sys);
		while (!ram_ready) begin
			n++;
			if (n > READY_LIMIT) begin
				$display("ram_ready_o stayed low for %0d cycles at %0t", READY_LIMIT, $time);
				$display("Test failed");
				$fatal(1, "Memory access timeout");
			end
			@(negedge clk_sys);
		end
	endtask

	task automatic cpu_read(input logic [15:0] a);
		cpu_addr   = a;
		cpu_mreq_n = 1'b0;
		cpu_rd_n   = 1'b0;
		wait_ready();
		expect_value("cpu_din_o", cpu_din, ref_mem[map_addr(a)]);
		step();
		cpu_mreq_n = 1'b1;
		cpu_rd_n   = 1'b1;
		step();
	endtask

	task automatic cpu_write(input logic [15:0] a, input logic [7:0] d);
		cpu_addr   = a;
		cpu_dout   = d;
		cpu_mreq_n = 1'b0;
		cpu_wr_n   = 1'b0;
		if (a[15:14] != 2'b00)
			ref_mem[map_addr(a)] = d;  // ROM keeps the downloaded byte
		wait_ready();
		step();
		cpu_mreq_n = 1'b1;
		cpu_wr_n   = 1'b1;
		step();
	endtask

	task automatic io_write(input logic [15:0] port, input logic [7:0] d);
		cpu_addr   = port;
		cpu_dout   = d;
		cpu_iorq_n = 1'b0;
		cpu_wr_n   = 1'b0;
		if (!port[15] && !port[1] && !mode_48k && !ref_page[5])
			ref_page = d;
		step();
		cpu_iorq_n = 1'b1;
		cpu_wr_n   = 1'b1;
		@(negedge clk_sys);
		expect_value("page_reg_o", page_reg, ref_page);
		step();
	endtask

	// Single strobe; callers keep 4 cycles between strobes
	task automatic download_byte(input logic [7:0] index, input logic [17:0] a,
		input logic [7:0] d);
		int base;
		base = (index == zx_mem_pkg::DL_INDEX_ROM) ?
			zx_mem_pkg::ROM_BASE : zx_mem_pkg::RAM_BASE;
		dl_index = index;
		dl_addr  = a;
		dl_data  = d;
		dl_wr    = 1'b1;
		ref_mem[base + int'(a)] = d;
		step();
		dl_wr = 1'b0;
	endtask

	task automatic next_ce(output int n);
		n = 0;
		do begin
			@(negedge clk_sys);
			n++;
			if (n > 64) begin
				$display("No ce_cpu_o pulse within 64 cycles at %0t", $time);
				$display("Test failed");
				$fatal(1, "Clock enable timeout");
			end
		end while (!ce_cpu);
	endtask

	task automatic measure_ce(input int t);
		int gap;
		int g;
		step();
		turbo = 3'(t);
		next_ce(gap);  // First pulse follows the stall
		for (g = 0; g < N_GAPS; g++) begin
			next_ce(gap);
			expect_value("ce_cpu_o period", gap, 1 << (5 - t));
		end
	endtask

	// ======================================================================
	// Test sequence
	// ======================================================================
	initial begin
		lfsr_q     = 16'd78;
		reset      = 1'b1;
		cpu_addr   = '0;
		cpu_dout   = '0;
		cpu_mreq_n = 1'b1;
		cpu_iorq_n = 1'b1;
		cpu_rd_n   = 1'b1;
		cpu_wr_n   = 1'b1;
		cpu_m1_n   = 1'b1;
		mode_48k   = 1'b0;
		turbo      = '0;
		dl_active  = 1'b0;
		dl_wr      = 1'b0;
		dl_index   = '0;
		dl_addr    = '0;
		dl_data    = '0;
		ref_page   = '0;
		apply_reset();

		// Both ROM pages from the download port
		dl_active = 1'b1;
		for (i = 0; i < ROM_BYTES; i++) begin
			download_byte(zx_mem_pkg::DL_INDEX_ROM, 18'(i), 8'(rand_bits(8)));
			repeat (3) step();
		end
		dl_active = 1'b0;
		step();
		mode_48k = 1'b1;
		for (i = 0; i < N_READS; i++)
			cpu_read({2'b00, 14'(rand_bits(14))});
		mode_48k = 1'b0;
		for (i = 0; i < N_READS; i++)
			cpu_read({2'b00, 14'(rand_bits(14))});
		io_write(16'h7FFD, 8'h10);
		for (i = 0; i < N_READS; i++)
			cpu_read({2'b00, 14'(rand_bits(14))});

		// ROM is write protected
		for (i = 0; i < N_READS; i++) begin
			offs[0] = 14'(rand_bits(14));
			cpu_write({2'b00, offs[0]}, 8'(rand_bits(8)));
			cpu_read({2'b00, offs[0]});
		end

		// Each bank at C000, then the fixed banks behind 4000 and 8000
		for (k = 0; k < N_OFFS; k++)
			offs[k] = 14'(rand_bits(14));
		for (i = 0; i < 8; i++) begin
			io_write(16'h7FFD, 8'(i));
			for (k = 0; k < N_OFFS; k++)
				cpu_write({2'b11, offs[k]}, 8'(rand_bits(8)));
		end
		for (i = 0; i < 8; i++) begin
			io_write(16'h7FFD, 8'(i));
			for (k = 0; k < N_OFFS; k++)
				cpu_read({2'b11, offs[k]});
		end
		for (k = 0; k < N_OFFS; k++) begin
			cpu_write({2'b01, offs[k]}, 8'(rand_bits(8)));
			cpu_write({2'b10, offs[k]}, 8'(rand_bits(8)));
		end
		io_write(16'h7FFD, 8'h05);
		for (k = 0; k < N_OFFS; k++)
			cpu_read({2'b11, offs[k]});
		io_write(16'h7FFD, 8'h02);
		for (k = 0; k < N_OFFS; k++)
			cpu_read({2'b11, offs[k]});

		// Lock bit holds the page until reset
		io_write(16'h7FFD, 8'h23);
		io_write(16'h7FFD, 8'h04);
		io_write(16'h7FFD, 8'h10);
		cpu_read({2'b11, offs[0]});
		apply_reset();
		mode_48k = 1'b1;
		io_write(16'h7FFD, 8'h07);
		mode_48k = 1'b0;

		// Loader into bank 7 racing CPU writes into bank 5
		io_write(16'h7FFD, 8'h07);
		for (i = 0; i < N_OVL; i++) begin
			ld_offs[i]  = 14'(rand_bits(14));
			cpu_offs[i] = 14'(rand_bits(14));
			dl_active   = 1'b1;
			download_byte(zx_mem_pkg::DL_INDEX_RAM, {1'b0, 3'd7, ld_offs[i]}, 8'(rand_bits(8)));
			dl_active = 1'b0;
			cpu_write({2'b01, cpu_offs[i]}, 8'(rand_bits(8)));
		end
		for (i = 0; i < N_OVL; i++) begin
			cpu_read({2'b11, ld_offs[i]});
			cpu_read({2'b01, cpu_offs[i]});
		end

		// CPU enable rate for every turbo step
		for (i = 0; i <= 4; i++)
			measure_ce(i);
		step();
		turbo = '0;
		repeat (8) step();

		if (u_zx_memory_top.u_zx_memory_props.fail_count == 0) begin
			$display("Test passed");
			$finish;
		end else begin
			$display("Test failed");
			$fatal(1, "Property failure");
		end
	end

endmodule

// File: src/clock_enables.sv
// CPU clock enable at 2**(CE_DIV_W - turbo) cycles; turbo at or above CE_DIV_W gives an enable every cycle
`timescale 1ns/1ns

module clock_enables #(
	parameter int CE_DIV_W = 5
) (
	input  logic               clk_sys,
	input  logic               reset,
	input  zx_mem_pkg::turbo_t turbo_i,
	input  logic               ram_ready_i,
	output logic               ce_cpu_o
);

	logic [CE_DIV_W-1:0] counter;
	logic [CE_DIV_W-1:0] div_mask;
	zx_mem_pkg::turbo_t  turbo_q;
	logic [1:0]          timeout;
	logic                tick_q;

	// Each turbo step halves the divide
	assign div_mask = {CE_DIV_W{1'b1}} >> turbo_q;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			counter <= '0;
			tick_q  <= 1'b0;
			turbo_q <= '0;
			timeout <= 2'd0;
		end else begin
			counter <= counter + 1'b1;
			tick_q  <= ((counter & div_mask) == '0);

			// Speed change holds the CPU off for a few cycles
			if (turbo_i != turbo_q) begin
				turbo_q <= turbo_i;
				timeout <= 2'd3;
			end else if (timeout != 2'd0) begin
				timeout <= timeout - 2'd1;
			end
		end
	end

	// Stall on pending memory or a speed change in progress
	assign ce_cpu_o = tick_q & ram_ready_i & (timeout == 2'd0) & (turbo_i == turbo_q);

endmodule

// File: src/cpu_port.sv
// CPU side of the shared memory; one request per bus cycle, ROM writes dropped, no requests during a download
`timescale 1ns/1ns

module cpu_port #(
	parameter int PHYS_ADDR_W = 18
) (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   cpu_mreq_n_i,
	input  logic                   cpu_rd_n_i,
	input  logic                   cpu_wr_n_i,
	input  zx_mem_pkg::byte_t      cpu_dout_i,
	input  logic                   dl_active_i,
	input  logic [PHYS_ADDR_W-1:0] phys_addr_i,
	input  logic                   wr_allowed_i,
	output logic                   cpu_req_o,
	output logic                   cpu_we_o,
	output logic [PHYS_ADDR_W-1:0] cpu_addr_o,
	output zx_mem_pkg::byte_t      cpu_wdata_o,
	input  logic                   cpu_ack_i,
	input  zx_mem_pkg::byte_t      cpu_rdata_i,
	output zx_mem_pkg::byte_t      cpu_din_o,
	output logic                   ram_ready_o
);

	logic              mem_rd;
	logic              mem_wr;
	logic              rd_q;
	logic              wr_q;
	logic              new_rd;
	logic              new_wr;
	logic              new_req;
	logic              done;
	logic              rd_pend;
	zx_mem_pkg::byte_t din_q;

	assign mem_rd  = ~cpu_mreq_n_i & ~cpu_rd_n_i;
	assign mem_wr  = ~cpu_mreq_n_i & ~cpu_wr_n_i;
	assign new_rd  = mem_rd & ~rd_q & ~dl_active_i;
	assign new_wr  = mem_wr & ~wr_q & wr_allowed_i & ~dl_active_i;
	assign new_req = new_rd | new_wr;
	assign done    = (cpu_ack_i == cpu_req_o);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rd_q      <= 1'b0;
			wr_q      <= 1'b0;
			cpu_req_o <= 1'b0;
			cpu_we_o  <= 1'b0;
			rd_pend   <= 1'b0;
		end else begin
			rd_q <= mem_rd;
			wr_q <= mem_wr;
			if (new_req) begin
				cpu_req_o <= ~cpu_req_o;  // Toggle starts a transfer
				cpu_we_o  <= new_wr;
				rd_pend   <= new_rd;
			end else if (done) begin
				rd_pend <= 1'b0;
			end
		end
	end

	// Request payload and read capture
	always_ff @(posedge clk_sys) begin
		if (new_req) begin
			cpu_addr_o  <= phys_addr_i;
			cpu_wdata_o <= cpu_dout_i;
		end
		if (rd_pend & done)
			din_q <= cpu_rdata_i;
	end

	// Fresh data in the same cycle that ram_ready rises
	assign cpu_din_o   = (rd_pend & done) ? cpu_rdata_i : din_q;
	assign ram_ready_o = done & ~new_req;

endmodule

// File: src/loader_port.sv
// Download writes into the shared memory; index 0 targets ROM, index 1 RAM, other indexes are ignored
`timescale 1ns/1ns

module loader_port #(
	parameter int PHYS_ADDR_W = 18
) (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   dl_active_i,
	input  logic                   dl_wr_i,
	input  zx_mem_pkg::byte_t      dl_index_i,
	input  logic [PHYS_ADDR_W-1:0] dl_addr_i,
	input  zx_mem_pkg::byte_t      dl_data_i,
	output logic                   ld_req_o,
	output logic [PHYS_ADDR_W-1:0] ld_addr_o,
	output zx_mem_pkg::byte_t      ld_wdata_o,
	input  logic                   ld_ack_i
);

	logic                   dl_wr_q;
	logic                   index_ok;
	logic                   strobe;
	logic                   idle;
	logic                   hold_v;
	logic                   issue_hold;
	logic                   issue_new;
	logic [PHYS_ADDR_W-1:0] base;
	logic [PHYS_ADDR_W-1:0] hold_addr;
	zx_mem_pkg::byte_t      hold_data;

	assign index_ok = (dl_index_i == zx_mem_pkg::DL_INDEX_ROM) |
		(dl_index_i == zx_mem_pkg::DL_INDEX_RAM);
	assign base = (dl_index_i == zx_mem_pkg::DL_INDEX_ROM) ?
		PHYS_ADDR_W'(zx_mem_pkg::ROM_BASE) : PHYS_ADDR_W'(zx_mem_pkg::RAM_BASE);

	assign strobe     = dl_active_i & dl_wr_i & ~dl_wr_q & index_ok;
	assign idle       = (ld_ack_i == ld_req_o);
	assign issue_hold = idle & hold_v;               // Parked byte goes first
	assign issue_new  = idle & ~hold_v & strobe;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			dl_wr_q  <= 1'b0;
			ld_req_o <= 1'b0;
			hold_v   <= 1'b0;
		end else begin
			dl_wr_q <= dl_wr_i;
			if (issue_hold | issue_new)
				ld_req_o <= ~ld_req_o;
			// Park a strobe that finds the port busy
			if (strobe & ~issue_new)
				hold_v <= 1'b1;
			else if (issue_hold)
				hold_v <= 1'b0;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (strobe) begin
			hold_addr <= base + dl_addr_i;
			hold_data <= dl_data_i;
		end
		if (issue_hold) begin
			ld_addr_o  <= hold_addr;
			ld_wdata_o <= hold_data;
		end else if (issue_new) begin
			ld_addr_o  <= base + dl_addr_i;
			ld_wdata_o <= dl_data_i;
		end
	end

endmodule

// File: src/page_control.sv
// 128K paging at 7FFD; lock bit 5 and 48K mode block writes, and only reset clears the lock
`timescale 1ns/1ns

module page_control #(
	parameter int PHYS_ADDR_W = 18
) (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic                  mode_48k_i,
	input  zx_mem_pkg::cpu_addr_t cpu_addr_i,
	input  zx_mem_pkg::byte_t     cpu_dout_i,
	input  logic                  cpu_iorq_n_i,
	input  logic                  cpu_wr_n_i,
	input  logic                  cpu_m1_n_i,
	output logic [PHYS_ADDR_W-1:0] phys_addr_o,
	output logic                  wr_allowed_o,
	output zx_mem_pkg::byte_t     page_reg_o
);

	logic                   io_wr;
	logic                   io_wr_q;
	logic                   port_hit;
	logic                   page_locked;
	logic                   rom_page;
	zx_mem_pkg::bank_t      bank;
	zx_mem_pkg::phys_addr_t mapped;

	// ======================================================================
	// Paging register
	// ======================================================================
	assign io_wr       = ~cpu_iorq_n_i & ~cpu_wr_n_i & cpu_m1_n_i;  // Not an INTA cycle
	assign port_hit    = (cpu_addr_i & zx_mem_pkg::PAGE_PORT_MASK) == 16'h0000;
	assign page_locked = mode_48k_i | page_reg_o[5];

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			io_wr_q    <= 1'b0;
			page_reg_o <= '0;
		end else begin
			io_wr_q <= io_wr;
			if (io_wr & ~io_wr_q & port_hit & ~page_locked)
				page_reg_o <= cpu_dout_i;
		end
	end

	// ======================================================================
	// CPU address to physical address
	// ======================================================================
	assign rom_page = mode_48k_i | page_reg_o[4];  // 48K BASIC lives in page 1

	always_comb begin
		bank         = 3'd0;
		wr_allowed_o = 1'b1;
		case (cpu_addr_i[15:14])
			2'b00: begin
				wr_allowed_o = 1'b0;  // ROM is read only
			end
			2'b01:   bank = 3'd5;
			2'b10:   bank = 3'd2;
			default: bank = mode_48k_i ? 3'd0 : page_reg_o[2:0];
		endcase

		if (cpu_addr_i[15:14] == 2'b00)
			mapped = zx_mem_pkg::ROM_BASE +
				zx_mem_pkg::phys_addr_t'({rom_page, cpu_addr_i[13:0]});
		else
			mapped = zx_mem_pkg::RAM_BASE +
				zx_mem_pkg::phys_addr_t'({bank, cpu_addr_i[13:0]});
	end

	assign phys_addr_o = PHYS_ADDR_W'(mapped);  // Upper bits zero for wider maps

endmodule

// File: src/ram_arbiter.sv
// Shared byte memory for two toggle-handshake ports; 2 cycles per access, alternating priority under contention
`timescale 1ns/1ns

module ram_arbiter #(
	parameter int PHYS_ADDR_W = 18
) (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   cpu_req_i,
	input  logic                   cpu_we_i,
	input  logic [PHYS_ADDR_W-1:0] cpu_addr_i,
	input  zx_mem_pkg::byte_t      cpu_wdata_i,
	output logic                   cpu_ack_o,
	output zx_mem_pkg::byte_t      cpu_rdata_o,
	input  logic                   ld_req_i,
	input  logic [PHYS_ADDR_W-1:0] ld_addr_i,
	input  zx_mem_pkg::byte_t      ld_wdata_i,
	output logic                   ld_ack_o
);

	localparam int MEM_AW = $bits(zx_mem_pkg::phys_addr_t);

	zx_mem_pkg::byte_t      mem [2**MEM_AW];
	zx_mem_pkg::arb_state_t state;
	logic                   cpu_pend;
	logic                   ld_pend;
	logic                   last_cpu;  // CPU was served most recently

	// A port is pending while its req differs from its ack
	assign cpu_pend = (cpu_req_i != cpu_ack_o);
	assign ld_pend  = (ld_req_i != ld_ack_o);

	// ======================================================================
	// Grant FSM
	// ======================================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state     <= zx_mem_pkg::IDLE;
			cpu_ack_o <= 1'b0;
			ld_ack_o  <= 1'b0;
			last_cpu  <= 1'b0;
		end else begin
			case (state)
				zx_mem_pkg::IDLE: begin
					if (cpu_pend & (~ld_pend | ~last_cpu))
						state <= zx_mem_pkg::SERVE_CPU;
					else if (ld_pend)
						state <= zx_mem_pkg::SERVE_LOADER;
				end
				zx_mem_pkg::SERVE_CPU: begin
					cpu_ack_o <= ~cpu_ack_o;
					last_cpu  <= 1'b1;
					state     <= zx_mem_pkg::IDLE;
				end
				zx_mem_pkg::SERVE_LOADER: begin
					ld_ack_o <= ~ld_ack_o;
					last_cpu <= 1'b0;
					state    <= zx_mem_pkg::IDLE;
				end
				default: state <= zx_mem_pkg::IDLE;
			endcase
		end
	end

	// ======================================================================
	// Memory array
	// ======================================================================
	// Requesters hold address and data until the ack, so no capture here
	always_ff @(posedge clk_sys) begin
		if (state == zx_mem_pkg::SERVE_CPU) begin
			if (cpu_we_i)
				mem[cpu_addr_i[MEM_AW-1:0]] <= cpu_wdata_i;
			else
				cpu_rdata_o <= mem[cpu_addr_i[MEM_AW-1:0]];  // Held until next CPU read
		end else if (state == zx_mem_pkg::SERVE_LOADER) begin
			mem[ld_addr_i[MEM_AW-1:0]] <= ld_wdata_i;
		end
	end

endmodule

// File: src/zx_mem_pkg.sv
// Widths, region bases and arbiter states for the memory side; physical map holds 8 RAM banks then 2 ROM pages
package zx_mem_pkg;

	// ======================================================================
	// Widths with a meaning
	// ======================================================================
	typedef logic [15:0] cpu_addr_t;   // Z80 address bus
	typedef logic [7:0]  byte_t;
	typedef logic [2:0]  bank_t;       // RAM bank 0..7
	typedef logic [17:0] phys_addr_t;  // Shared memory address
	typedef logic [2:0]  turbo_t;      // 0 normal, 4 fastest

	// ======================================================================
	// Physical memory map
	// ======================================================================
	// Eight 16K banks from the bottom
	localparam phys_addr_t RAM_BASE = 18'h00000;
	// Two 16K ROM pages above the RAM
	localparam phys_addr_t ROM_BASE = 18'h20000;

	// Port 7FFD decodes on A15 low and A1 low only
	localparam cpu_addr_t PAGE_PORT_MASK = 16'h8002;

	// Download target selection
	localparam byte_t DL_INDEX_ROM = 8'd0;
	localparam byte_t DL_INDEX_RAM = 8'd1;

	// Shared memory arbiter
	typedef enum logic [1:0] {
		IDLE,
		SERVE_CPU,
		SERVE_LOADER
	} arb_state_t;

endpackage

// File: src/zx_memory_top.sv
// Memory side of the Spectrum host; CPU bus comes in as loose pins and must wait on ram_ready_o
`timescale 1ns/1ns

module zx_memory_top #(
	parameter int PHYS_ADDR_W = 18,
	parameter int CE_DIV_W    = 5
) (
	input  logic                   clk_sys,
	input  logic                   reset,
	// Z80 bus
	input  zx_mem_pkg::cpu_addr_t  cpu_addr_i,
	input  zx_mem_pkg::byte_t      cpu_dout_i,
	input  logic                   cpu_mreq_n_i,
	input  logic                   cpu_iorq_n_i,
	input  logic                   cpu_rd_n_i,
	input  logic                   cpu_wr_n_i,
	input  logic                   cpu_m1_n_i,
	input  logic                   mode_48k_i,
	input  zx_mem_pkg::turbo_t     turbo_i,
	// File download
	input  logic                   dl_active_i,
	input  logic                   dl_wr_i,
	input  zx_mem_pkg::byte_t      dl_index_i,
	input  logic [PHYS_ADDR_W-1:0] dl_addr_i,
	input  zx_mem_pkg::byte_t      dl_data_i,
	output zx_mem_pkg::byte_t      cpu_din_o,
	output logic                   ram_ready_o,
	output logic                   ce_cpu_o,
	output zx_mem_pkg::byte_t      page_reg_o
);

	logic [PHYS_ADDR_W-1:0] phys_addr;
	logic                   wr_allowed;
	logic                   cpu_req, cpu_we, cpu_ack;
	logic [PHYS_ADDR_W-1:0] cpu_addr;
	zx_mem_pkg::byte_t      cpu_wdata, cpu_rdata;
	logic                   ld_req, ld_ack;
	logic [PHYS_ADDR_W-1:0] ld_addr;
	zx_mem_pkg::byte_t      ld_wdata;

	clock_enables #(.CE_DIV_W(CE_DIV_W)) u_clock_enables (
		.clk_sys, .reset, .turbo_i,
		.ram_ready_i (ram_ready_o),
		.ce_cpu_o
	);

	page_control #(.PHYS_ADDR_W(PHYS_ADDR_W)) u_page_control (
		.clk_sys, .reset, .mode_48k_i, .cpu_addr_i, .cpu_dout_i,
		.cpu_iorq_n_i, .cpu_wr_n_i, .cpu_m1_n_i,
		.phys_addr_o  (phys_addr),
		.wr_allowed_o (wr_allowed),
		.page_reg_o
	);

	cpu_port #(.PHYS_ADDR_W(PHYS_ADDR_W)) u_cpu_port (
		.clk_sys, .reset, .cpu_mreq_n_i, .cpu_rd_n_i, .cpu_wr_n_i, .cpu_dout_i,
		.dl_active_i,
		.phys_addr_i  (phys_addr),
		.wr_allowed_i (wr_allowed),
		.cpu_req_o    (cpu_req),
		.cpu_we_o     (cpu_we),
		.cpu_addr_o   (cpu_addr),
		.cpu_wdata_o  (cpu_wdata),
		.cpu_ack_i    (cpu_ack),
		.cpu_rdata_i  (cpu_rdata),
		.cpu_din_o, .ram_ready_o
	);

	loader_port #(.PHYS_ADDR_W(PHYS_ADDR_W)) u_loader_port (
		.clk_sys, .reset, .dl_active_i, .dl_wr_i, .dl_index_i, .dl_addr_i, .dl_data_i,
		.ld_req_o   (ld_req),
		.ld_addr_o  (ld_addr),
		.ld_wdata_o (ld_wdata),
		.ld_ack_i   (ld_ack)
	);

	ram_arbiter #(.PHYS_ADDR_W(PHYS_ADDR_W)) u_ram_arbiter (
		.clk_sys, .reset,
		.cpu_req_i   (cpu_req),
		.cpu_we_i    (cpu_we),
		.cpu_addr_i  (cpu_addr),
		.cpu_wdata_i (cpu_wdata),
		.cpu_ack_o   (cpu_ack),
		.cpu_rdata_o (cpu_rdata),
		.ld_req_i    (ld_req),
		.ld_addr_i   (ld_addr),
		.ld_wdata_i  (ld_wdata),
		.ld_ack_o    (ld_ack)
	);

endmodule

// File: vlog.f
src/zx_mem_pkg.sv
src/clock_enables.sv
src/page_control.sv
src/cpu_port.sv
src/loader_port.sv
src/ram_arbiter.sv
src/zx_memory_top.sv
dv/zx_memory_props.sv
dv/zx_memory_tb.sv
